// File: project.f
bc_msg_pkg.sv
bc_msg_in_reg.sv
bc_msg_arbiter.sv
bc_msg_merger.sv
bc_region_mem.sv
bc_msg_top.sv
tb_bc_msg_top.sv

// File: run.sh
#!/bin/sh
# Build the broadcast message testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_bc_msg_top \
  -f project.f \
  -o tb_sim

./obj_dir/tb_sim

// File: tb_bc_msg_top.sv
// Testbench for bc_msg_top with message table, delivery monitor and region check
`timescale 1ns/1ps
`default_nettype none

module tb_bc_msg_top;

  localparam int entry_count = 24;
  localparam int word_count  = 2**bc_msg_pkg::addr_width;
  localparam int wait_limit  = 400;

  logic clk;
  logic rst;
  bc_msg_pkg::msg_t [bc_msg_pkg::core_count-1:0]                 s_data;
  bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0]             s_user;
  logic [bc_msg_pkg::core_count-1:0]                             s_valid;
  logic [bc_msg_pkg::core_count-1:0]                             s_ready;
  bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0]             m_user;
  logic [bc_msg_pkg::core_count-1:0]                             m_valid;
  logic [bc_msg_pkg::core_count-1:0][bc_msg_pkg::addr_width-1:0] rd_addr;
  bc_msg_pkg::word_t [bc_msg_pkg::core_count-1:0]                rd_data;

  // Message table with one masked write per entry
  bc_msg_pkg::core_id_t              tbl_src  [entry_count];
  logic [bc_msg_pkg::addr_width-1:0] tbl_addr [entry_count];
  bc_msg_pkg::word_t                 tbl_data [entry_count];
  logic [bc_msg_pkg::mask_width-1:0] tbl_mask [entry_count];
  int                                gap      [entry_count];
  logic                              b2b      [entry_count];

  // Per-core entry lists in table order
  int core_idx [bc_msg_pkg::core_count][entry_count];
  int core_n   [bc_msg_pkg::core_count];
  int next_k   [bc_msg_pkg::core_count];
  int others_since [bc_msg_pkg::core_count];

  bc_msg_pkg::word_t model_mem [word_count];
  int   xfer_edge    [entry_count];
  int   deliver_edge [entry_count];
  int   cycle_cnt;
  int   delivered;
  int   seed;
  logic started;
  logic monitor_on;

  bc_msg_top bc_msg_top_inst (
    .clk     (clk),
    .rst     (rst),
    .s_data  (s_data),
    .s_user  (s_user),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_user  (m_user),
    .m_valid (m_valid),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_msg(input string name, input bc_msg_pkg::msg_t got,
                           input bc_msg_pkg::msg_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch time=%0t signal=%s got=%h expected=%h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_user(input string name, input bc_msg_pkg::core_id_t got,
                            input bc_msg_pkg::core_id_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch time=%0t signal=%s got=%0d expected=%0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input bc_msg_pkg::word_t got,
                            input bc_msg_pkg::word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch time=%0t signal=%s got=%h expected=%h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_ready(input string name,
                             input logic [bc_msg_pkg::core_count-1:0] got,
                             input logic [bc_msg_pkg::core_count-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch time=%0t signal=%s got=%b expected=%b",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("mismatch time=%0t signal=%s got=%0d expected=%0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic set_entry(input int i, input int src, input int addr,
                           input bc_msg_pkg::word_t data, input int mask);
    tbl_src[i]  = bc_msg_pkg::core_id_t'(src);
    tbl_addr[i] = addr[bc_msg_pkg::addr_width-1:0];
    tbl_data[i] = data;
    tbl_mask[i] = mask[bc_msg_pkg::mask_width-1:0];
  endtask

  // Data on top, then mask, then address
  function automatic bc_msg_pkg::msg_t pack_msg(input int i);
    return {tbl_data[i], tbl_mask[i], tbl_addr[i]};
  endfunction

  task automatic load_table();
    int c;
    set_entry(0,  0, 'h01, 32'ha0a1_a2a3, 'hf);
    set_entry(1,  1, 'h11, 32'hb0b1_b2b3, 'hf);
    set_entry(2,  2, 'h21, 32'hc0c1_c2c3, 'hf);
    set_entry(3,  3, 'h31, 32'hd0d1_d2d3, 'hf);
    set_entry(4,  0, 'h01, 32'h1122_3344, 'h3);
    set_entry(5,  1, 'h11, 32'h5566_7788, 'hc);
    set_entry(6,  2, 'h22, 32'h99aa_bbcc, 'h5);
    set_entry(7,  3, 'h31, 32'hddee_ff00, 'ha);
    set_entry(8,  0, 'h02, 32'h1234_5678, 'hf);
    set_entry(9,  1, 'h12, 32'h9abc_def0, 'h1);
    set_entry(10, 2, 'h21, 32'h0f1e_2d3c, 'h8);
    set_entry(11, 3, 'h32, 32'h4b5a_6978, 'h6);
    set_entry(12, 0, 'h01, 32'hdead_beef, 'h4);
    set_entry(13, 1, 'h11, 32'hcafe_f00d, 'h2);
    set_entry(14, 2, 'h22, 32'h1357_9bdf, 'hf);
    set_entry(15, 3, 'h32, 32'h2468_ace0, 'h9);
    set_entry(16, 0, 'h02, 32'hfedc_ba98, 'hc);
    set_entry(17, 1, 'h12, 32'h7654_3210, 'he);
    set_entry(18, 2, 'h21, 32'ha5a5_a5a5, 'h3);
    set_entry(19, 3, 'h31, 32'h5a5a_5a5a, 'h7);
    set_entry(20, 0, 'h02, 32'h0102_0304, 'h1);
    set_entry(21, 1, 'h12, 32'h0a0b_0c0d, 'hf);
    // Empty mask leaves the region untouched
    set_entry(22, 2, 'h22, 32'hf0f0_f0f0, 'h0);
    set_entry(23, 3, 'h32, 32'h3333_3333, 'hb);
    seed = 64286;
    for (int n = 0; n < bc_msg_pkg::core_count; n++) begin
      core_n[n] = 0;
      next_k[n] = 0;
      others_since[n] = 0;
    end
    for (int i = 0; i < entry_count; i++) begin
      c = int'(tbl_src[i]);
      gap[i] = (($unsigned($random(seed)) % 8) < 2) ? 1 + ($unsigned($random(seed)) % 3) : 0;
      // Back-to-back only when the previous message of the core was posted in the same phase
      b2b[i] = (gap[i] == 0) && (core_n[c] > 0) && (core_idx[c][core_n[c]-1] != 0);
      core_idx[c][core_n[c]] = i;
      core_n[c]++;
    end
  endtask

  // Expected region with writes applied in table order
  task automatic build_model();
    for (int a = 0; a < word_count; a++) begin
      model_mem[a] = '0;
    end
    for (int i = 0; i < entry_count; i++) begin
      for (int b = 0; b < bc_msg_pkg::mask_width; b++) begin
        if (tbl_mask[i][b]) begin
          model_mem[tbl_addr[i]][8*b +: 8] = tbl_data[i][8*b +: 8];
        end
      end
    end
  endtask

  task automatic send_msg(input int c, input int i);
    int waited;
    s_data[c]  = pack_msg(i);
    s_user[c]  = bc_msg_pkg::core_id_t'(c);
    s_valid[c] = 1'b1;
    waited     = 0;
    @(negedge clk);
    while (!s_ready[c]) begin
      if (waited == wait_limit) begin
        report_failure($sformatf("core %0d message %0d was never accepted", c, i));
      end
      waited++;
      @(negedge clk);
    end
    // Transfer happens at the coming edge
    xfer_edge[i] = cycle_cnt + 1;
    started      = 1'b1;
    @(posedge clk);
    #1;
    s_valid[c] = 1'b0;
  endtask

  task automatic drive_core(input int c);
    int i;
    for (int k = 0; k < core_n[c]; k++) begin
      i = core_idx[c][k];
      if (i != 0) begin
        repeat (gap[i]) begin
          @(posedge clk);
          #1;
        end
        send_msg(c, i);
      end
    end
  endtask

  task automatic wait_delivered(input int target);
    int waited;
    waited = 0;
    while (delivered < target) begin
      if (waited == 20 * wait_limit) begin
        report_failure($sformatf("only %0d of %0d messages delivered", delivered, target));
      end
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic record_delivery();
    int u;
    int i;
    u = int'(m_user[0]);
    if (next_k[u] >= core_n[u]) begin
      report_failure($sformatf("core %0d got more deliveries than it posted", u));
    end
    i = core_idx[u][next_k[u]];
    next_k[u]++;
    for (int n = 0; n < bc_msg_pkg::core_count; n++) begin
      check_user($sformatf("m_user[%0d]", n), m_user[n], tbl_src[i]);
      check_msg($sformatf("lane_data[%0d]", n), bc_msg_top_inst.lane_data[n], pack_msg(i));
    end
    deliver_edge[i] = cycle_cnt + 1;
    if (b2b[i] && others_since[u] > 3) begin
      report_failure($sformatf("core %0d waited for %0d other deliveries", u, others_since[u]));
    end
    for (int n = 0; n < bc_msg_pkg::core_count; n++) begin
      others_since[n] = (n == u) ? 0 : others_since[n] + 1;
    end
    delivered++;
  endtask

  // Outputs only change at rising edges
  always @(negedge clk) begin
    if (monitor_on) begin
      if (!started && (|m_valid)) begin
        report_failure("m_valid went high before any message was accepted");
      end
      if (m_valid != '0 && m_valid != '1) begin
        report_failure("lanes disagree on m_valid");
      end
      if (m_valid[0]) begin
        record_delivery();
      end
    end
  end

  task automatic check_regions();
    for (int a = 0; a < word_count; a++) begin
      @(posedge clk);
      #1;
      for (int n = 0; n < bc_msg_pkg::core_count; n++) begin
        rd_addr[n] = a[bc_msg_pkg::addr_width-1:0];
      end
      @(posedge clk);
      @(negedge clk);
      for (int n = 0; n < bc_msg_pkg::core_count; n++) begin
        check_word($sformatf("rd_data[%0d] addr %0d", n, a), rd_data[n], model_mem[a]);
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    s_data     = '0;
    s_user     = '0;
    s_valid    = '0;
    rd_addr    = '0;
    cycle_cnt  = 0;
    delivered  = 0;
    started    = 1'b0;
    monitor_on = 1'b0;
    load_table();
    build_model();
    repeat (8) @(posedge clk);
    #1;
    rst        = 1'b0;
    monitor_on = 1'b1;
    // Ready is low for the first cycle after reset and high from then on
    @(negedge clk);
    check_ready("s_ready", s_ready, '0);
    @(negedge clk);
    check_ready("s_ready", s_ready, '1);
    // Region clear runs during the idle time
    repeat (69) @(posedge clk);
    #1;
    send_msg(0, 0);
    wait_delivered(1);
    check_count("latency of entry 0", deliver_edge[0] - xfer_edge[0], 5);
    @(posedge clk);
    #1;
    fork
      drive_core(0);
      drive_core(1);
      drive_core(2);
      drive_core(3);
    join
    wait_delivered(entry_count);
    check_regions();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bc_msg_top.sv
// Top level with the broadcast merger and one region memory per core
`timescale 1ns/1ps
`default_nettype none

module bc_msg_top (
  input  wire                                                  clk,
  input  wire                                                  rst,

  // Core message streams
  input  wire bc_msg_pkg::msg_t [bc_msg_pkg::core_count-1:0]     s_data,
  input  wire bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0] s_user,
  input  wire [bc_msg_pkg::core_count-1:0]                     s_valid,
  output wire [bc_msg_pkg::core_count-1:0]                     s_ready,

  // Delivery seen by each core
  output wire bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0] m_user,
  output wire [bc_msg_pkg::core_count-1:0]                     m_valid,

  // Region read ports
  input  wire [bc_msg_pkg::core_count-1:0][bc_msg_pkg::addr_width-1:0] rd_addr,
  output wire bc_msg_pkg::word_t [bc_msg_pkg::core_count-1:0]    rd_data
);

  // Broadcast data, one lane per core
  wire bc_msg_pkg::msg_t [bc_msg_pkg::core_count-1:0] lane_data;

  bc_msg_merger merger_inst (
    .clk     (clk),
    .rst     (rst),
    .s_data  (s_data),
    .s_user  (s_user),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_data  (lane_data),
    .m_user  (m_user),
    .m_valid (m_valid)
  );

  for (genvar n = 0; n < bc_msg_pkg::core_count; n++) begin : regions
    bc_region_mem region_mem_inst (
      .clk      (clk),
      .rst      (rst),
      .bc_data  (lane_data[n]),
      .bc_valid (m_valid[n]),
      .rd_addr  (rd_addr[n]),
      .rd_data  (rd_data[n])
    );
  end

endmodule

`default_nettype wire

// File: bc_region_mem.sv
// One core's broadcast region with byte-masked write and registered read
`timescale 1ns/1ps
`default_nettype none

module bc_region_mem (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire bc_msg_pkg::msg_t               bc_data,
  input  wire                                 bc_valid,
  input  wire [bc_msg_pkg::addr_width-1:0]    rd_addr,
  output bc_msg_pkg::word_t                   rd_data
);

  bc_msg_pkg::word_t mem [2**bc_msg_pkg::addr_width];

  // Message fields
  logic [bc_msg_pkg::addr_width-1:0] wr_addr;
  logic [bc_msg_pkg::mask_width-1:0] wr_mask;
  bc_msg_pkg::word_t                 wr_word;

  // Clear sweep, started by reset and run one word per cycle
  logic [bc_msg_pkg::addr_width-1:0] clr_addr;
  logic                              clr_busy;

  assign wr_addr = bc_data[bc_msg_pkg::addr_lsb +: bc_msg_pkg::addr_width];
  assign wr_mask = bc_data[bc_msg_pkg::mask_lsb +: bc_msg_pkg::mask_width];
  assign wr_word = bc_data[bc_msg_pkg::data_lsb +: bc_msg_pkg::data_width];

  always_ff @(posedge clk) begin
    if (rst) begin
      clr_addr <= '0;
      clr_busy <= 1'b1;
    end else if (clr_busy) begin
      clr_addr <= clr_addr + 1'b1;
      if (clr_addr == '1) begin
        clr_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clr_busy && !rst) begin
      mem[clr_addr] <= '0;
    end else if (bc_valid) begin
      // Only bytes with their mask bit set
      for (int b = 0; b < bc_msg_pkg::mask_width; b++) begin
        if (wr_mask[b]) begin
          mem[wr_addr][8*b +: 8] <= wr_word[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: bc_msg_merger.sv
// Input slices, two-level arbiter and two-level fan-out of the merged stream
`timescale 1ns/1ps
`default_nettype none

module bc_msg_merger (
  input  wire                                                  clk,
  input  wire                                                  rst,
  input  wire bc_msg_pkg::msg_t [bc_msg_pkg::core_count-1:0]     s_data,
  input  wire bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0] s_user,
  input  wire [bc_msg_pkg::core_count-1:0]                     s_valid,
  output wire [bc_msg_pkg::core_count-1:0]                     s_ready,
  output wire bc_msg_pkg::msg_t [bc_msg_pkg::core_count-1:0]     m_data,
  output wire bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0] m_user,
  output wire [bc_msg_pkg::core_count-1:0]                     m_valid
);

  // Registered core streams into the arbiter
  wire bc_msg_pkg::msg_t [bc_msg_pkg::core_count-1:0]     core_data;
  wire bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0] core_user;
  wire [bc_msg_pkg::core_count-1:0]                       core_valid;
  wire [bc_msg_pkg::core_count-1:0]                       core_ready;

  wire bc_msg_pkg::msg_t     merged_data;
  wire bc_msg_pkg::core_id_t merged_user;
  wire                       merged_valid;

  for (genvar n = 0; n < bc_msg_pkg::core_count; n++) begin : in_slices
    bc_msg_in_reg in_reg_inst (
      .clk     (clk),
      .rst     (rst),
      .s_data  (s_data[n]),
      .s_user  (s_user[n]),
      .s_valid (s_valid[n]),
      .s_ready (s_ready[n]),
      .m_data  (core_data[n]),
      .m_user  (core_user[n]),
      .m_valid (core_valid[n]),
      .m_ready (core_ready[n])
    );
  end

  // Cores always accept, so the merged stream never stalls
  bc_msg_arbiter arbiter_inst (
    .clk     (clk),
    .rst     (rst),
    .s_data  (core_data),
    .s_user  (core_user),
    .s_valid (core_valid),
    .s_ready (core_ready),
    .m_data  (merged_data),
    .m_user  (merged_user),
    .m_valid (merged_valid),
    .m_ready (1'b1)
  );

  // First fan-out level, one copy per cluster
  (* keep = "true" *) bc_msg_pkg::msg_t [bc_msg_pkg::cluster_count-1:0]     cl_data_r;
  (* keep = "true" *) bc_msg_pkg::core_id_t [bc_msg_pkg::cluster_count-1:0] cl_user_r;
  (* keep = "true" *) logic [bc_msg_pkg::cluster_count-1:0]                 cl_valid_r;

  // Second level, one copy per core lane
  (* keep = "true" *) bc_msg_pkg::msg_t [bc_msg_pkg::core_count-1:0]     lane_data_r;
  (* keep = "true" *) bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0] lane_user_r;
  (* keep = "true" *) logic [bc_msg_pkg::core_count-1:0]                 lane_valid_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      cl_valid_r   <= '0;
      lane_valid_r <= '0;
    end else begin
      cl_valid_r <= {bc_msg_pkg::cluster_count{merged_valid}};
      for (int n = 0; n < bc_msg_pkg::core_count; n++) begin
        lane_valid_r[n] <= cl_valid_r[n / bc_msg_pkg::cores_per_cluster];
      end
    end
  end

  always_ff @(posedge clk) begin
    cl_data_r <= {bc_msg_pkg::cluster_count{merged_data}};
    cl_user_r <= {bc_msg_pkg::cluster_count{merged_user}};
    // Lanes of a cluster share its copy
    for (int n = 0; n < bc_msg_pkg::core_count; n++) begin
      lane_data_r[n] <= cl_data_r[n / bc_msg_pkg::cores_per_cluster];
      lane_user_r[n] <= cl_user_r[n / bc_msg_pkg::cores_per_cluster];
    end
  end

  assign m_data  = lane_data_r;
  assign m_user  = lane_user_r;
  assign m_valid = lane_valid_r;

endmodule

`default_nettype wire

// File: bc_msg_arbiter.sv
// Two-level round-robin arbiter, per-cluster stage then cluster merge stage
`timescale 1ns/1ps
`default_nettype none

module bc_msg_arbiter (
  input  wire                                                  clk,
  input  wire                                                  rst,
  input  wire bc_msg_pkg::msg_t [bc_msg_pkg::core_count-1:0]     s_data,
  input  wire bc_msg_pkg::core_id_t [bc_msg_pkg::core_count-1:0] s_user,
  input  wire [bc_msg_pkg::core_count-1:0]                     s_valid,
  output logic [bc_msg_pkg::core_count-1:0]                    s_ready,
  output bc_msg_pkg::msg_t                                     m_data,
  output bc_msg_pkg::core_id_t                                 m_user,
  output logic                                                 m_valid,
  input  wire                                                  m_ready
);

  // Cluster stage registers
  bc_msg_pkg::msg_t [bc_msg_pkg::cluster_count-1:0]     cl_data;
  bc_msg_pkg::core_id_t [bc_msg_pkg::cluster_count-1:0] cl_user;
  logic [bc_msg_pkg::cluster_count-1:0]                 cl_valid;
  logic [bc_msg_pkg::cluster_count-1:0]                 cl_ready;

  bc_msg_pkg::msg_t [bc_msg_pkg::cluster_count-1:0]     cl_next_data;
  bc_msg_pkg::core_id_t [bc_msg_pkg::cluster_count-1:0] cl_next_user;
  logic [bc_msg_pkg::core_count-1:0]                    cl_grant;
  // Per cluster, marks requesters above the last granted one
  logic [bc_msg_pkg::core_count-1:0]                    cl_mask;
  logic [bc_msg_pkg::core_count-1:0]                    cl_mask_next;

  // Merge stage
  logic [bc_msg_pkg::cluster_count-1:0] top_pick;
  logic [bc_msg_pkg::cluster_count-1:0] top_grant;
  logic [bc_msg_pkg::cluster_count-1:0] top_mask;
  logic [bc_msg_pkg::cluster_count-1:0] top_mask_next;
  bc_msg_pkg::msg_t                     top_data;
  bc_msg_pkg::core_id_t                 top_user;
  logic                                 out_ready;

  assign out_ready = !m_valid || m_ready;
  assign cl_ready  = ~cl_valid | top_grant;
  assign s_ready   = cl_grant;

  always_comb begin
    logic [bc_msg_pkg::cores_per_cluster-1:0] pick;
    logic                                     found;
    logic                                     seen;
    cl_grant     = '0;
    cl_mask_next = cl_mask;
    cl_next_data = '0;
    cl_next_user = '0;
    for (int c = 0; c < bc_msg_pkg::cluster_count; c++) begin
      pick  = '0;
      found = 1'b0;
      // Requesters after the last grant first, then wrap
      for (int i = 0; i < bc_msg_pkg::cores_per_cluster; i++) begin
        if (!found && s_valid[c*bc_msg_pkg::cores_per_cluster+i] &&
            cl_mask[c*bc_msg_pkg::cores_per_cluster+i]) begin
          pick[i] = 1'b1;
          found   = 1'b1;
        end
      end
      for (int i = 0; i < bc_msg_pkg::cores_per_cluster; i++) begin
        if (!found && s_valid[c*bc_msg_pkg::cores_per_cluster+i]) begin
          pick[i] = 1'b1;
          found   = 1'b1;
        end
      end
      seen = 1'b0;
      for (int i = 0; i < bc_msg_pkg::cores_per_cluster; i++) begin
        if (pick[i]) begin
          cl_next_data[c] = s_data[c*bc_msg_pkg::cores_per_cluster+i];
          cl_next_user[c] = s_user[c*bc_msg_pkg::cores_per_cluster+i];
        end
        if (cl_ready[c] && found) begin
          cl_mask_next[c*bc_msg_pkg::cores_per_cluster+i] = seen;
        end
        seen = seen | pick[i];
      end
      if (cl_ready[c]) begin
        cl_grant[c*bc_msg_pkg::cores_per_cluster +: bc_msg_pkg::cores_per_cluster] = pick;
      end
    end
  end

  always_comb begin
    logic found;
    logic seen;
    top_pick = '0;
    found    = 1'b0;
    for (int i = 0; i < bc_msg_pkg::cluster_count; i++) begin
      if (!found && cl_valid[i] && top_mask[i]) begin
        top_pick[i] = 1'b1;
        found       = 1'b1;
      end
    end
    for (int i = 0; i < bc_msg_pkg::cluster_count; i++) begin
      if (!found && cl_valid[i]) begin
        top_pick[i] = 1'b1;
        found       = 1'b1;
      end
    end
    top_grant     = out_ready ? top_pick : '0;
    top_mask_next = top_mask;
    top_data      = '0;
    top_user      = '0;
    seen          = 1'b0;
    for (int i = 0; i < bc_msg_pkg::cluster_count; i++) begin
      if (top_pick[i]) begin
        top_data = cl_data[i];
        top_user = cl_user[i];
      end
      if (|top_grant) begin
        top_mask_next[i] = seen;
      end
      seen = seen | top_pick[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cl_valid <= '0;
      cl_mask  <= '1;
      top_mask <= '1;
      m_valid  <= 1'b0;
    end else begin
      cl_mask  <= cl_mask_next;
      top_mask <= top_mask_next;
      for (int c = 0; c < bc_msg_pkg::cluster_count; c++) begin
        if (cl_ready[c]) begin
          cl_valid[c] <= |cl_grant[c*bc_msg_pkg::cores_per_cluster +:
                                   bc_msg_pkg::cores_per_cluster];
        end
      end
      if (out_ready) begin
        m_valid <= |top_grant;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < bc_msg_pkg::cluster_count; c++) begin
      if (cl_ready[c]) begin
        cl_data[c] <= cl_next_data[c];
        cl_user[c] <= cl_next_user[c];
      end
    end
    if (|top_grant) begin
      m_data <= top_data;
      m_user <= top_user;
    end
  end

endmodule

`default_nettype wire

// File: bc_msg_in_reg.sv
// Two-entry skid register slice with registered ready for one core stream
`timescale 1ns/1ps
`default_nettype none

module bc_msg_in_reg (
  input  wire                       clk,
  input  wire                       rst,
  input  wire bc_msg_pkg::msg_t     s_data,
  input  wire bc_msg_pkg::core_id_t s_user,
  input  wire                       s_valid,
  output logic                      s_ready,
  output bc_msg_pkg::msg_t          m_data,
  output bc_msg_pkg::core_id_t      m_user,
  output logic                      m_valid,
  input  wire                       m_ready
);

  // Skid entry, filled when the output stalls
  bc_msg_pkg::msg_t     skid_data;
  bc_msg_pkg::core_id_t skid_user;
  logic                 skid_valid;

  logic ready_next;
  logic in_to_out;
  logic in_to_skid;
  logic skid_to_out;

  // Ready next cycle if output drains or skid stays empty
  assign ready_next  = m_ready || (!skid_valid && (!m_valid || !s_valid));
  assign in_to_out   = s_ready && (m_ready || !m_valid);
  assign in_to_skid  = s_ready && m_valid && !m_ready;
  assign skid_to_out = !s_ready && m_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      s_ready    <= 1'b0;
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      s_ready <= ready_next;
      if (in_to_out) begin
        m_valid <= s_valid;
      end else if (skid_to_out) begin
        m_valid <= skid_valid;
      end
      if (in_to_skid) begin
        skid_valid <= s_valid;
      end else if (skid_to_out) begin
        skid_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_to_out) begin
      m_data <= s_data;
      m_user <= s_user;
    end else if (skid_to_out) begin
      m_data <= skid_data;
      m_user <= skid_user;
    end
    if (in_to_skid) begin
      skid_data <= s_data;
      skid_user <= s_user;
    end
  end

endmodule

`default_nettype wire

// File: bc_msg_pkg.sv
// Broadcast message sizes, field positions and shared types
`default_nettype none

package bc_msg_pkg;

  // Cluster shape
  localparam int core_count        = 4;
  localparam int cluster_count     = 2;
  localparam int cores_per_cluster = core_count / cluster_count;
  localparam int core_width        = $clog2(core_count);

  // Broadcast region, addressed in 32-bit words
  localparam int region_bytes = 256;
  localparam int addr_width   = $clog2(region_bytes) - 2;

  // Payload of one masked write
  localparam int data_width = 32;
  localparam int mask_width = data_width / 8;

  // Message word is data, then mask, then address, from the top
  localparam int msg_width = data_width + mask_width + addr_width;
  localparam int addr_lsb  = 0;
  localparam int mask_lsb  = addr_lsb + addr_width;
  localparam int data_lsb  = mask_lsb + mask_width;

  // One broadcast message
  typedef logic [msg_width-1:0] msg_t;

  // Source core id, carried as user field
  typedef logic [core_width-1:0] core_id_t;

  // One region word
  typedef logic [data_width-1:0] word_t;

endpackage

`default_nettype wire
